// File: design/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// cores with a private register set
`define DMA_NUM_CTRL 4

// scratch memory geometry, 32-bit words
`define DMA_MEM_WORDS 256
`define DMA_MEM_AW 8

// register port word address width
`define DMA_REG_AW 3

// transfer id width, zero-extended on reads
`define DMA_ID_W 28

// register word offsets
`define DMA_REG_SRC 3'd0
`define DMA_REG_DST 3'd1
`define DMA_REG_NUM 3'd2
`define DMA_REG_NEXT_ID 3'd3
`define DMA_REG_DONE 3'd4
`define DMA_REG_STATUS 3'd5

// returned for unmapped register reads
`define DMA_BAD_ACCESS 32'hbadacce5

`endif

// File: design/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

    typedef logic [`DMA_MEM_AW-1:0] mem_addr_t;
    typedef logic [`DMA_ID_W-1:0] transfer_id_t;

    // one queued copy job, as handed from a core to the engine
    typedef struct packed {
        mem_addr_t   src_addr;
        mem_addr_t   dst_addr;
        logic [31:0] num_words;
    } transf_descr_t;

    // single access on the scratch memory port
    typedef struct packed {
        logic        we;
        mem_addr_t   addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

// File: design/dma_ctrl_regs.sv
`include "dma_params.svh"

module dma_ctrl_regs import dma_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic [`DMA_REG_AW-1:0] addr_i,
    input  logic [31:0]            wdata_i,
    output logic                   gnt_o,
    output logic                   rvalid_o,
    output logic [31:0]            rdata_o,
    output logic                   launch_req_o,
    input  logic                   launch_gnt_i,
    output transf_descr_t          descr_o,
    input  logic [`DMA_ID_W-1:0]   next_id_i,
    input  logic [`DMA_ID_W-1:0]   done_id_i,
    input  logic                   busy_i
);

    logic [31:0] src_q;
    logic [31:0] dst_q;
    logic [31:0] num_q;
    logic [31:0] rdata_d;
    logic        accept;

    // a launch read with work to do waits for the descriptor arbiter
    assign launch_req_o = req_i && !we_i && (addr_i == `DMA_REG_NEXT_ID) && (num_q != '0);
    assign gnt_o        = req_i && (!launch_req_o || launch_gnt_i);
    assign accept       = req_i && gnt_o;

    always_comb begin
        descr_o.src_addr  = src_q[`DMA_MEM_AW-1:0];
        descr_o.dst_addr  = dst_q[`DMA_MEM_AW-1:0];
        descr_o.num_words = num_q;
    end

    always_comb begin
        case (addr_i)
            `DMA_REG_SRC:     rdata_d = src_q;
            `DMA_REG_DST:     rdata_d = dst_q;
            `DMA_REG_NUM:     rdata_d = num_q;
            // zero-length launch returns id 0 and issues nothing
            `DMA_REG_NEXT_ID: rdata_d = (num_q != '0) ? 32'(next_id_i) : 32'd0;
            `DMA_REG_DONE:    rdata_d = 32'(done_id_i);
            `DMA_REG_STATUS:  rdata_d = {31'd0, busy_i};
            default:          rdata_d = `DMA_BAD_ACCESS;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            src_q    <= '0;
            dst_q    <= '0;
            num_q    <= '0;
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= accept && !we_i;
            if (accept && we_i) begin
                case (addr_i)
                    `DMA_REG_SRC: src_q <= wdata_i;
                    `DMA_REG_DST: dst_q <= wdata_i;
                    `DMA_REG_NUM: num_q <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !we_i) begin
            rdata_o <= rdata_d;
        end
    end

    // a stalled access keeps its request, direction and address until granted
    a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && !gnt_o |=> req_i && $stable(we_i) && $stable(addr_i));

endmodule

// File: design/dma_rr_arbiter.sv
`include "dma_params.svh"

module dma_rr_arbiter import dma_pkg::*; #(
    parameter int unsigned NUM_IN = `DMA_NUM_CTRL,
    parameter type payload_t = transf_descr_t
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [NUM_IN-1:0]         req_i,
    output logic [NUM_IN-1:0]         gnt_o,
    input  payload_t [NUM_IN-1:0]     data_i,
    output logic                      req_o,
    input  logic                      gnt_i,
    output payload_t                  data_o,
    output logic [$clog2(NUM_IN)-1:0] idx_o
);

    localparam int unsigned IDX_W = $clog2(NUM_IN);

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] lock_idx_q;
    logic             lock_q;
    logic [IDX_W-1:0] rr_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             rr_found;

    // first requester after the last one served
    always_comb begin
        int unsigned cand;
        rr_found = 1'b0;
        rr_idx   = last_q;
        for (int unsigned i = 1; i <= NUM_IN; i++) begin
            cand = (int'(last_q) + i) % NUM_IN;
            if (!rr_found && req_i[cand]) begin
                rr_found = 1'b1;
                rr_idx   = IDX_W'(cand);
            end
        end
    end

    assign sel_idx = lock_q ? lock_idx_q : rr_idx;
    assign req_o   = req_i[sel_idx];
    assign data_o  = data_i[sel_idx];
    assign idx_o   = sel_idx;

    always_comb begin
        gnt_o          = '0;
        gnt_o[sel_idx] = req_o && gnt_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q     <= IDX_W'(NUM_IN - 1);
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            // hold the choice while downstream is busy
            lock_q     <= req_o && !gnt_i;
            lock_idx_q <= sel_idx;
            if (req_o && gnt_i) begin
                last_q <= sel_idx;
            end
        end
    end

    // a waiting requester stays up until it is served
    a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i & ~gnt_o) != '0 |=> ($past(req_i & ~gnt_o) & ~req_i) == '0);

endmodule

// File: design/dma_copy_engine.sv
`include "dma_params.svh"

module dma_copy_engine import dma_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          start_i,
    input  transf_descr_t descr_i,
    output logic          ready_o,
    output logic          mem_req_o,
    output mem_req_t      mem_o,
    input  logic          mem_gnt_i,
    input  logic          mem_rvalid_i,
    input  logic [31:0]   mem_rdata_i,
    output logic          idle_o,
    output logic          trans_complete_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e        state_q;
    transf_descr_t descr_q;
    logic [31:0]   cnt_q;
    logic [31:0]   data_q;
    logic          last_word;

    assign ready_o          = (state_q == ST_IDLE);
    assign idle_o           = (state_q == ST_IDLE);
    assign trans_complete_o = (state_q == ST_DONE);
    assign mem_req_o        = (state_q == ST_READ) || (state_q == ST_WRITE);
    assign last_word        = (cnt_q == descr_q.num_words - 32'd1);

    // addresses wrap with the memory width
    always_comb begin
        mem_o.we    = (state_q == ST_WRITE);
        mem_o.addr  = (state_q == ST_WRITE) ? descr_q.dst_addr + cnt_q[`DMA_MEM_AW-1:0]
                                            : descr_q.src_addr + cnt_q[`DMA_MEM_AW-1:0];
        mem_o.wdata = data_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= ST_READ;
                    end
                end
                ST_READ: if (mem_gnt_i) state_q <= ST_WAIT;
                ST_WAIT: if (mem_rvalid_i) state_q <= ST_WRITE;
                ST_WRITE: begin
                    if (mem_gnt_i) begin
                        cnt_q   <= cnt_q + 32'd1;
                        state_q <= last_word ? ST_DONE : ST_READ;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && ready_o) begin
            descr_q <= descr_i;
        end
        // word held between its read and its write
        if (state_q == ST_WAIT && mem_rvalid_i) begin
            data_q <= mem_rdata_i;
        end
    end

    // a waiting descriptor is held by the arbiter and its core until taken
    a_start_held: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i && !ready_o |=> start_i && $stable(descr_i));

    a_start_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i && ready_o |-> descr_i.num_words != '0);

endmodule

// File: design/dma_transfer_id_gen.sv
`include "dma_params.svh"

module dma_transfer_id_gen import dma_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 issue_i,
    input  logic                 retire_i,
    output logic [`DMA_ID_W-1:0] next_o,
    output logic [`DMA_ID_W-1:0] completed_o
);

    transfer_id_t next_q;
    transfer_id_t done_q;

    // both counters wrap at the id width
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            next_q <= '0;
            done_q <= '0;
        end else begin
            if (issue_i) next_q <= next_q + transfer_id_t'(1);
            if (retire_i) done_q <= done_q + transfer_id_t'(1);
        end
    end

    assign next_o      = next_q;
    assign completed_o = done_q;

    // the engine only retires what was issued before
    a_no_overtake: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_i |-> next_q != done_q);

endmodule

// File: design/dma_scratch_mem.sv
`include "dma_params.svh"

module dma_scratch_mem (
    input  logic              clk_i,
    input  logic              req_i,
    input  dma_pkg::mem_req_t mem_i,
    output logic [31:0]       rdata_o
);

    logic [31:0] mem_q [`DMA_MEM_WORDS];

    // registered read, data follows the request by one cycle
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (mem_i.we) begin
                mem_q[mem_i.addr] <= mem_i.wdata;
            end else begin
                rdata_o <= mem_q[mem_i.addr];
            end
        end
    end

endmodule

// File: design/dma_cluster_top.sv
`include "dma_params.svh"

module dma_cluster_top import dma_pkg::*; (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic [`DMA_NUM_CTRL-1:0]                   core_req_i,
    input  logic [`DMA_NUM_CTRL-1:0]                   core_we_i,
    input  logic [`DMA_NUM_CTRL-1:0][`DMA_REG_AW-1:0]  core_addr_i,
    input  logic [`DMA_NUM_CTRL-1:0][31:0]             core_wdata_i,
    output logic [`DMA_NUM_CTRL-1:0]                   core_gnt_o,
    output logic [`DMA_NUM_CTRL-1:0]                   core_rvalid_o,
    output logic [`DMA_NUM_CTRL-1:0][31:0]             core_rdata_o,
    input  logic                                       host_req_i,
    input  logic                                       host_we_i,
    input  logic [`DMA_MEM_AW-1:0]                     host_addr_i,
    input  logic [31:0]                                host_wdata_i,
    output logic                                       host_gnt_o,
    output logic                                       host_rvalid_o,
    output logic [31:0]                                host_rdata_o,
    output logic                                       busy_o,
    output logic [`DMA_NUM_CTRL-1:0]                   term_event_o
);

    transf_descr_t [`DMA_NUM_CTRL-1:0] descr;
    logic [`DMA_NUM_CTRL-1:0]          launch_req;
    logic [`DMA_NUM_CTRL-1:0]          launch_gnt;
    transf_descr_t                     descr_arb;
    logic                              start;
    logic                              eng_ready;
    logic                              eng_idle;
    logic                              complete;
    logic [`DMA_ID_W-1:0]              next_id;
    logic [`DMA_ID_W-1:0]              done_id;

    mem_req_t [1:0]                    mem_cand;
    logic [1:0]                        mem_cand_req;
    logic [1:0]                        mem_cand_gnt;
    mem_req_t                          mem_sel;
    logic                              mem_req;
    logic [0:0]                        mem_idx;
    logic [31:0]                       mem_rdata;
    logic                              rd_valid_q;
    logic [0:0]                        rd_idx_q;

    for (genvar i = 0; i < `DMA_NUM_CTRL; i++) begin : gen_ctrl_regs
        dma_ctrl_regs u_regs (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .req_i       (core_req_i[i]),
            .we_i        (core_we_i[i]),
            .addr_i      (core_addr_i[i]),
            .wdata_i     (core_wdata_i[i]),
            .gnt_o       (core_gnt_o[i]),
            .rvalid_o    (core_rvalid_o[i]),
            .rdata_o     (core_rdata_o[i]),
            .launch_req_o(launch_req[i]),
            .launch_gnt_i(launch_gnt[i]),
            .descr_o     (descr[i]),
            .next_id_i   (next_id),
            .done_id_i   (done_id),
            .busy_i      (busy_o)
        );
    end

    dma_rr_arbiter #(
        .NUM_IN   (`DMA_NUM_CTRL),
        .payload_t(transf_descr_t)
    ) u_descr_arb (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (launch_req),
        .gnt_o (launch_gnt),
        .data_i(descr),
        .req_o (start),
        .gnt_i (eng_ready),
        .data_o(descr_arb),
        .idx_o ()
    );

    dma_copy_engine u_engine (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_i         (start),
        .descr_i         (descr_arb),
        .ready_o         (eng_ready),
        .mem_req_o       (mem_cand_req[0]),
        .mem_o           (mem_cand[0]),
        .mem_gnt_i       (mem_cand_gnt[0]),
        .mem_rvalid_i    (rd_valid_q && rd_idx_q == 1'b0),
        .mem_rdata_i     (mem_rdata),
        .idle_o          (eng_idle),
        .trans_complete_o(complete)
    );

    // one issue per descriptor taken by the engine
    dma_transfer_id_gen u_id_gen (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .issue_i    (start && eng_ready),
        .retire_i   (complete),
        .next_o     (next_id),
        .completed_o(done_id)
    );

    // host is requester 1 on the memory
    always_comb begin
        mem_cand_req[1]   = host_req_i;
        mem_cand[1].we    = host_we_i;
        mem_cand[1].addr  = host_addr_i;
        mem_cand[1].wdata = host_wdata_i;
    end

    dma_rr_arbiter #(
        .NUM_IN   (2),
        .payload_t(mem_req_t)
    ) u_mem_arb (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (mem_cand_req),
        .gnt_o (mem_cand_gnt),
        .data_i(mem_cand),
        .req_o (mem_req),
        .gnt_i (1'b1),
        .data_o(mem_sel),
        .idx_o (mem_idx)
    );

    dma_scratch_mem u_mem (
        .clk_i  (clk_i),
        .req_i  (mem_req),
        .mem_i  (mem_sel),
        .rdata_o(mem_rdata)
    );

    // remember who got the read so its data goes back there
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_q <= 1'b0;
            rd_idx_q   <= '0;
        end else begin
            rd_valid_q <= mem_req && !mem_sel.we;
            rd_idx_q   <= mem_idx;
        end
    end

    assign host_gnt_o    = mem_cand_gnt[1];
    assign host_rvalid_o = rd_valid_q && rd_idx_q == 1'b1;
    assign host_rdata_o  = mem_rdata;

    assign busy_o       = ~eng_idle;
    assign term_event_o = {`DMA_NUM_CTRL{complete}};

endmodule

// File: verification/dma_tb.sv
`include "dma_params.svh"

module dma_tb;

    localparam int NC       = `DMA_NUM_CTRL;
    localparam int WAIT_MAX = 2000;

    logic                            clk;
    logic                            rst;
    logic [NC-1:0]                   core_req;
    logic [NC-1:0]                   core_we;
    logic [NC-1:0][`DMA_REG_AW-1:0]  core_addr;
    logic [NC-1:0][31:0]             core_wdata;
    logic [NC-1:0]                   core_gnt;
    logic [NC-1:0]                   core_rvalid;
    logic [NC-1:0][31:0]             core_rdata;
    logic                            host_req;
    logic                            host_we;
    logic [`DMA_MEM_AW-1:0]          host_addr;
    logic [31:0]                     host_wdata;
    logic                            host_gnt;
    logic                            host_rvalid;
    logic [31:0]                     host_rdata;
    logic                            busy;
    logic [NC-1:0]                   term_event;

    int          errors;
    int          errs_mark;
    int          tests;
    logic [31:0] model [`DMA_MEM_WORDS];

    dma_cluster_top u_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .core_req_i   (core_req),
        .core_we_i    (core_we),
        .core_addr_i  (core_addr),
        .core_wdata_i (core_wdata),
        .core_gnt_o   (core_gnt),
        .core_rvalid_o(core_rvalid),
        .core_rdata_o (core_rdata),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_gnt_o   (host_gnt),
        .host_rvalid_o(host_rvalid),
        .host_rdata_o (host_rdata),
        .busy_o       (busy),
        .term_event_o (term_event)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4;
            clk = ~clk;
        end
    end

    for (genvar c = 0; c < NC; c++) begin : gen_rvalid_chk
        a_core_rvalid: assert property (@(posedge clk) disable iff (rst)
            core_req[c] && core_gnt[c] && !core_we[c] |=> core_rvalid[c])
        else begin
            errors++;
            $display("core %0d gave no read data one cycle after an accepted read", c);
        end
    end

    a_host_rvalid: assert property (@(posedge clk) disable iff (rst)
        host_req && host_gnt && !host_we |=> host_rvalid)
    else begin
        errors++;
        $display("host port gave no read data one cycle after an accepted read");
    end

    // completion goes to every core at once
    a_term_equal: assert property (@(posedge clk) disable iff (rst)
        term_event == '0 || term_event == '1)
    else begin
        errors++;
        $display("completion event bits differ between cores");
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // called and left 1 time unit after a rising edge
    task automatic core_access(input int c, input logic we, input logic [`DMA_REG_AW-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int t;
        t             = 0;
        core_req[c]   = 1'b1;
        core_we[c]    = we;
        core_addr[c]  = addr;
        core_wdata[c] = wdata;
        @(negedge clk);
        while (!core_gnt[c] && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (!core_gnt[c]) begin
            errors++;
            $display("timeout: core %0d was never granted at register %0d", c, addr);
        end
        @(posedge clk);
        #1;
        core_req[c] = 1'b0;
        // registered read data is settled by now
        rdata = core_rdata[c];
    endtask

    task automatic core_write(input int c, input logic [`DMA_REG_AW-1:0] addr,
                              input logic [31:0] wdata);
        logic [31:0] unused;
        core_access(c, 1'b1, addr, wdata, unused);
    endtask

    task automatic core_read(input int c, input logic [`DMA_REG_AW-1:0] addr,
                             output logic [31:0] rdata);
        core_access(c, 1'b0, addr, 32'd0, rdata);
    endtask

    task automatic host_access(input logic we, input logic [`DMA_MEM_AW-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int t;
        t          = 0;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        @(negedge clk);
        while (!host_gnt && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (!host_gnt) begin
            errors++;
            $display("timeout: host was never granted at address %h", addr);
        end
        @(posedge clk);
        #1;
        host_req = 1'b0;
        rdata    = host_rdata;
    endtask

    task automatic fill_block(input logic [`DMA_MEM_AW-1:0] base, input int n);
        logic [31:0]            v;
        logic [31:0]            unused;
        logic [`DMA_MEM_AW-1:0] a;
        for (int i = 0; i < n; i++) begin
            v        = $urandom();
            a        = `DMA_MEM_AW'(base + i);
            model[a] = v;
            host_access(1'b1, a, v, unused);
        end
    endtask

    // host reads at dst must match what was written at src
    task automatic check_block(input string name, input logic [`DMA_MEM_AW-1:0] src,
                               input logic [`DMA_MEM_AW-1:0] dst, input int n);
        logic [31:0] rd;
        for (int i = 0; i < n; i++) begin
            host_access(1'b0, `DMA_MEM_AW'(dst + i), 32'd0, rd);
            compare_word(name, model[`DMA_MEM_AW'(src + i)], rd);
        end
    endtask

    task automatic launch(input int c, input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] n, output logic [31:0] id);
        core_write(c, `DMA_REG_SRC, src);
        core_write(c, `DMA_REG_DST, dst);
        core_write(c, `DMA_REG_NUM, n);
        core_read(c, `DMA_REG_NEXT_ID, id);
    endtask

    task automatic wait_term();
        int t;
        t = 0;
        @(negedge clk);
        while (!term_event[0] && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (!term_event[0]) begin
            errors++;
            $display("timeout: no completion event after a launch");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - errs_mark);
        errs_mark = errors;
        tests++;
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] id_a;
        logic [31:0] id_b;
        errors     = 0;
        errs_mark  = 0;
        tests      = 0;
        v          = $urandom(32'h4822_bd6f);
        rst        = 1'b1;
        core_req   = '0;
        core_we    = '0;
        core_addr  = '0;
        core_wdata = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < 3; r++) begin
            v = $urandom();
            core_write(3, `DMA_REG_AW'(r), v);
            core_read(3, `DMA_REG_AW'(r), rd);
            compare_word("register readback", v, rd);
        end
        end_test("register readback");

        fill_block(8'h10, 8);
        launch(0, 32'h10, 32'h40, 32'd8, id_a);
        compare_word("single copy id", 32'd0, id_a);
        wait_term();
        check_block("single copy data", 8'h10, 8'h40, 8);
        core_read(0, `DMA_REG_DONE, rd);
        compare_word("single copy done", 32'd1, rd);
        end_test("single copy");

        fill_block(8'h20, 6);
        fill_block(8'h30, 5);
        fork
            launch(1, 32'h20, 32'h60, 32'd6, id_a);
            launch(2, 32'h30, 32'h70, 32'd5, id_b);
        join
        // the order between the two cores is up to the arbiter
        compare_word("concurrent low id", 32'd1, (id_a < id_b) ? id_a : id_b);
        compare_word("concurrent high id", 32'd2, (id_a < id_b) ? id_b : id_a);
        wait_term();
        check_block("concurrent copy core 1", 8'h20, 8'h60, 6);
        check_block("concurrent copy core 2", 8'h30, 8'h70, 5);
        core_read(1, `DMA_REG_DONE, rd);
        compare_word("concurrent done", 32'd3, rd);
        end_test("concurrent launches");

        core_write(3, `DMA_REG_NUM, 32'd0);
        core_read(3, `DMA_REG_NEXT_ID, rd);
        compare_word("zero length id", 32'd0, rd);
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            assert (term_event == '0)
            else begin
                errors++;
                $display("completion event seen after a zero-length launch");
            end
        end
        @(posedge clk);
        #1;
        core_read(3, `DMA_REG_DONE, rd);
        compare_word("zero length done", 32'd3, rd);
        end_test("zero-length launch");

        launch(0, 32'h80, 32'hc0, 32'd32, id_a);
        compare_word("busy during copy", 32'd1, 32'(busy));
        core_read(2, `DMA_REG_STATUS, rd);
        compare_word("status busy", 32'd1, rd);
        wait_term();
        compare_word("busy after copy", 32'd0, 32'(busy));
        core_read(2, `DMA_REG_STATUS, rd);
        compare_word("status idle", 32'd0, rd);
        core_read(2, 3'd7, rd);
        compare_word("unmapped read", `DMA_BAD_ACCESS, rd);
        end_test("status and unmapped");

        fill_block(8'h90, 16);
        launch(1, 32'h90, 32'hd0, 32'd16, id_a);
        fork
            check_block("host reads during copy", 8'h90, 8'h90, 16);
            wait_term();
        join
        check_block("copy under contention", 8'h90, 8'hd0, 16);
        end_test("host contention");

        $display("summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+design
design/dma_pkg.sv
design/dma_ctrl_regs.sv
design/dma_rr_arbiter.sv
design/dma_copy_engine.sv
design/dma_transfer_id_gen.sv
design/dma_scratch_mem.sv
design/dma_cluster_top.sv
verification/dma_tb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= dma_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
